/* source/spritePkg.sv */
// sprite package with pixel types, scene colors and the girder rectangle table

package spritePkg;

    // ------------------------------
    // vector types
    // ------------------------------

    // screen coordinate, also used for the barrel radius
    typedef logic [9:0] coordT;

    // 4 bits each of red, green, blue
    typedef logic [11:0] colorT;

    typedef logic [3:0] digitT;

    // frames remaining on the countdown
    typedef logic [15:0] frameCountT;

    // ------------------------------
    // scene colors
    // ------------------------------

    localparam colorT BarrelColor = 12'hD60;
    localparam colorT DigitColor  = 12'hFFF;
    localparam colorT GirderColor = 12'hB04;
    localparam colorT BackColor   = 12'h000;

    // ------------------------------
    // girder rectangles
    // ------------------------------

    // six girders, then the top platform
    localparam int GirderCount = 7;

    // x bounds are exclusive, y bounds inclusive
    localparam coordT GirderLeft [GirderCount] = '{
        10'd30, 10'd30, 10'd80, 10'd30, 10'd80, 10'd30, 10'd125
    };
    localparam coordT GirderRight [GirderCount] = '{
        10'd610, 10'd560, 10'd610, 10'd560, 10'd610, 10'd560, 10'd200
    };
    localparam coordT GirderTop [GirderCount] = '{
        10'd430, 10'd370, 10'd310, 10'd250, 10'd190, 10'd130, 10'd90
    };
    localparam coordT GirderBottom [GirderCount] = '{
        10'd440, 10'd380, 10'd320, 10'd260, 10'd200, 10'd140, 10'd100
    };

endpackage

/* source/apbRegs.sv */
// APB slave holding the barrel positions, the barrel size and the timer restart command
`timescale 1ns/1ps

module apbRegs (
    input  logic             frame_clk,
    input  logic             reset,
    input  logic             PSEL,
    input  logic             PENABLE,
    input  logic             PWRITE,
    input  logic [7:0]       PADDR,
    input  logic [15:0]      PWDATA,
    output logic [15:0]      PRDATA,
    output logic             PREADY,
    output logic             PSLVERR,
    output spritePkg::coordT barrel0X,
    output spritePkg::coordT barrel0Y,
    output spritePkg::coordT barrel1X,
    output spritePkg::coordT barrel1Y,
    output spritePkg::coordT barrelSize,
    output logic             timerRestart
);

    // register map
    localparam logic [7:0] AddrBarrel0X   = 8'h00;
    localparam logic [7:0] AddrBarrel0Y   = 8'h04;
    localparam logic [7:0] AddrBarrel1X   = 8'h08;
    localparam logic [7:0] AddrBarrel1Y   = 8'h0C;
    localparam logic [7:0] AddrBarrelSize = 8'h10;
    localparam logic [7:0] AddrControl    = 8'h14;

    // barrels start off screen
    localparam logic [9:0] OffScreen   = 10'd700;
    localparam logic [9:0] DefaultSize = 10'd8;

    logic        access;
    logic        writeEn;
    logic        addrMapped;
    logic [15:0] readData;

    assign PREADY  = 1'b1;
    assign access  = PSEL & PENABLE;
    assign writeEn = access & PWRITE & addrMapped;
    assign PSLVERR = access & ~addrMapped;
    assign PRDATA  = (access && !PWRITE) ? readData : 16'd0;

    // address decode and read mux
    always_comb begin
        addrMapped = 1'b1;
        readData   = 16'd0;
        case (PADDR)
            AddrBarrel0X:   readData = {6'd0, barrel0X};
            AddrBarrel0Y:   readData = {6'd0, barrel0Y};
            AddrBarrel1X:   readData = {6'd0, barrel1X};
            AddrBarrel1Y:   readData = {6'd0, barrel1Y};
            AddrBarrelSize: readData = {6'd0, barrelSize};
            AddrControl:    readData = 16'd0;
            default:        addrMapped = 1'b0;
        endcase
    end

    // ------------------------------
    // write side
    // ------------------------------

    always_ff @(posedge frame_clk or posedge reset) begin
        if (reset) begin
            barrel0X   <= OffScreen;
            barrel0Y   <= OffScreen;
            barrel1X   <= OffScreen;
            barrel1Y   <= OffScreen;
            barrelSize <= DefaultSize;
        end else if (writeEn) begin
            case (PADDR)
                AddrBarrel0X:   barrel0X   <= PWDATA[9:0];
                AddrBarrel0Y:   barrel0Y   <= PWDATA[9:0];
                AddrBarrel1X:   barrel1X   <= PWDATA[9:0];
                AddrBarrel1Y:   barrel1Y   <= PWDATA[9:0];
                AddrBarrelSize: barrelSize <= PWDATA[9:0];
                default: ;
            endcase
        end
    end

    // one-cycle restart pulse, timer reloads on the next edge
    always_ff @(posedge frame_clk or posedge reset) begin
        if (reset) begin
            timerRestart <= 1'b0;
        end else begin
            timerRestart <= writeEn && (PADDR == AddrControl) && PWDATA[0];
        end
    end

endmodule

/* source/countdownTimer.sv */
// frame countdown timer with seconds split into three decimal digits
`timescale 1ns/1ps

module countdownTimer #(
    parameter int TimerStart      = 6059,
    parameter int FramesPerSecond = 60
) (
    input  logic                  frame_clk,
    input  logic                  reset,
    input  logic                  frameStart,
    input  logic                  timerRestart,
    output spritePkg::frameCountT timeLeft,
    output spritePkg::digitT      hundreds,
    output spritePkg::digitT      tens,
    output spritePkg::digitT      ones
);

    import spritePkg::*;

    frameCountT seconds;

    // restart takes priority over a frame tick
    always_ff @(posedge frame_clk or posedge reset) begin
        if (reset) begin
            timeLeft <= frameCountT'(TimerStart);
        end else if (timerRestart) begin
            timeLeft <= frameCountT'(TimerStart);
        end else if (frameStart && (timeLeft != '0)) begin
            timeLeft <= timeLeft - 1'b1;
        end
    end

    // whole seconds, then decimal split
    assign seconds  = timeLeft / frameCountT'(FramesPerSecond);
    assign hundreds = digitT'(seconds / frameCountT'(100));
    assign tens     = digitT'((seconds % frameCountT'(100)) / frameCountT'(10));
    assign ones     = digitT'(seconds % frameCountT'(10));

endmodule

/* source/digitGlyph.sv */
// seven-segment renderer deciding whether one pixel of an 8x16 digit cell is lit
`timescale 1ns/1ps

module digitGlyph (
    input  spritePkg::digitT digit,
    input  logic [2:0]       cellX,
    input  logic [3:0]       cellY,
    output logic             lit
);

    // segment order a b c d e f g, msb first
    logic [6:0] segOn;
    logic [6:0] segArea;

    always_comb begin
        case (digit)
            4'd0:    segOn = 7'b1111110;
            4'd1:    segOn = 7'b0110000;
            4'd2:    segOn = 7'b1101101;
            4'd3:    segOn = 7'b1111001;
            4'd4:    segOn = 7'b0110011;
            4'd5:    segOn = 7'b1011011;
            4'd6:    segOn = 7'b1011111;
            4'd7:    segOn = 7'b1110000;
            4'd8:    segOn = 7'b1111111;
            4'd9:    segOn = 7'b1111011;
            default: segOn = 7'b0000000;
        endcase
    end

    // horizontal bars span columns 1..6
    assign segArea[6] = (cellY <= 4'd1) && (cellX >= 3'd1) && (cellX <= 3'd6);
    assign segArea[0] = (cellY >= 4'd7) && (cellY <= 4'd8)
                        && (cellX >= 3'd1) && (cellX <= 3'd6);
    assign segArea[3] = (cellY >= 4'd14) && (cellX >= 3'd1) && (cellX <= 3'd6);

    // upper verticals
    assign segArea[5] = (cellX >= 3'd6) && (cellY >= 4'd1) && (cellY <= 4'd7);
    assign segArea[1] = (cellX <= 3'd1) && (cellY >= 4'd1) && (cellY <= 4'd7);

    // lower verticals
    assign segArea[4] = (cellX >= 3'd6) && (cellY >= 4'd8) && (cellY <= 4'd14);
    assign segArea[2] = (cellX <= 3'd1) && (cellY >= 4'd8) && (cellY <= 4'd14);

    assign lit = |(segOn & segArea);

endmodule

/* source/sceneHitTest.sv */
// first pixel stage: tests barrels, girders and timer digits and registers the hit flags
`timescale 1ns/1ps

module sceneHitTest (
    input  logic             frame_clk,
    input  logic             reset,
    input  spritePkg::coordT drawX,
    input  spritePkg::coordT drawY,
    input  spritePkg::coordT barrel0X,
    input  spritePkg::coordT barrel0Y,
    input  spritePkg::coordT barrel1X,
    input  spritePkg::coordT barrel1Y,
    input  spritePkg::coordT barrelSize,
    input  spritePkg::digitT hundreds,
    input  spritePkg::digitT tens,
    input  spritePkg::digitT ones,
    output logic             barrelHit,
    output logic             digitHit,
    output logic             girderHit
);

    import spritePkg::*;

    logic  barrelNext;
    logic  girderNext;
    logic  digitNext;
    logic  inDigitArea;
    logic  glyphLit;
    digitT cellDigit;

    // squared distance from center against squared radius
    function automatic logic circleHit(input coordT px, input coordT py,
                                       input coordT cx, input coordT cy,
                                       input coordT radius);
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        logic [22:0]        distSq;
        logic [22:0]        radSq;
        dx     = $signed({1'b0, px}) - $signed({1'b0, cx});
        dy     = $signed({1'b0, py}) - $signed({1'b0, cy});
        distSq = 23'(dx * dx) + 23'(dy * dy);
        radSq  = {13'd0, radius} * {13'd0, radius};
        return distSq <= radSq;
    endfunction

    assign barrelNext = circleHit(drawX, drawY, barrel0X, barrel0Y, barrelSize)
                        || circleHit(drawX, drawY, barrel1X, barrel1Y, barrelSize);

    // scan the girder table
    always_comb begin
        girderNext = 1'b0;
        for (int i = 0; i < GirderCount; i++) begin
            if ((drawX > GirderLeft[i]) && (drawX < GirderRight[i])
                    && (drawY >= GirderTop[i]) && (drawY <= GirderBottom[i])) begin
                girderNext = 1'b1;
            end
        end
    end

    // ------------------------------
    // timer digits, top-left corner
    // ------------------------------

    assign inDigitArea = (drawX < coordT'(24)) && (drawY < coordT'(16));

    // 8-pixel column picks the digit
    always_comb begin
        case (drawX[4:3])
            2'd0:    cellDigit = hundreds;
            2'd1:    cellDigit = tens;
            default: cellDigit = ones;
        endcase
    end

    digitGlyph glyph (
        .digit (cellDigit),
        .cellX (drawX[2:0]),
        .cellY (drawY[3:0]),
        .lit   (glyphLit)
    );

    assign digitNext = inDigitArea & glyphLit;

    always_ff @(posedge frame_clk or posedge reset) begin
        if (reset) begin
            barrelHit <= 1'b0;
            digitHit  <= 1'b0;
            girderHit <= 1'b0;
        end else begin
            barrelHit <= barrelNext;
            digitHit  <= digitNext;
            girderHit <= girderNext;
        end
    end

endmodule

/* source/pixelMixer.sv */
// second pixel stage: picks the pixel color by fixed priority and registers it
`timescale 1ns/1ps

module pixelMixer (
    input  logic             frame_clk,
    input  logic             reset,
    input  logic             barrelHit,
    input  logic             digitHit,
    input  logic             girderHit,
    output spritePkg::colorT rgb
);

    import spritePkg::*;

    colorT colorNext;

    // barrel over digit over girder over background
    always_comb begin
        if (barrelHit) begin
            colorNext = BarrelColor;
        end else if (digitHit) begin
            colorNext = DigitColor;
        end else if (girderHit) begin
            colorNext = GirderColor;
        end else begin
            colorNext = BackColor;
        end
    end

    always_ff @(posedge frame_clk or posedge reset) begin
        if (reset) begin
            rgb <= BackColor;
        end else begin
            rgb <= colorNext;
        end
    end

endmodule

/* source/donkeyScreen.sv */
// pixel engine top level joining the APB registers, timer, hit test and color mixer
`timescale 1ns/1ps

module donkeyScreen #(
    parameter int TimerStart      = 6059,
    parameter int FramesPerSecond = 60
) (
    input  logic                  frame_clk,
    input  logic                  reset,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    input  logic                  PWRITE,
    input  logic [7:0]            PADDR,
    input  logic [15:0]           PWDATA,
    output logic [15:0]           PRDATA,
    output logic                  PREADY,
    output logic                  PSLVERR,
    input  logic                  frameStart,
    input  spritePkg::coordT      drawX,
    input  spritePkg::coordT      drawY,
    output spritePkg::colorT      rgb,
    output spritePkg::frameCountT timeLeft
);

    import spritePkg::*;

    coordT barrel0X;
    coordT barrel0Y;
    coordT barrel1X;
    coordT barrel1Y;
    coordT barrelSize;
    logic  timerRestart;
    digitT hundreds;
    digitT tens;
    digitT ones;
    logic  barrelHit;
    logic  digitHit;
    logic  girderHit;

    // ------------------------------
    // input side
    // ------------------------------

    apbRegs regs (
        .frame_clk, .reset,
        .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
        .PRDATA, .PREADY, .PSLVERR,
        .barrel0X, .barrel0Y, .barrel1X, .barrel1Y, .barrelSize,
        .timerRestart
    );

    countdownTimer #(
        .TimerStart      (TimerStart),
        .FramesPerSecond (FramesPerSecond)
    ) timer (
        .frame_clk, .reset, .frameStart, .timerRestart,
        .timeLeft, .hundreds, .tens, .ones
    );

    // ------------------------------
    // pixel pipeline, two stages
    // ------------------------------

    sceneHitTest hitTest (
        .frame_clk, .reset, .drawX, .drawY,
        .barrel0X, .barrel0Y, .barrel1X, .barrel1Y, .barrelSize,
        .hundreds, .tens, .ones,
        .barrelHit, .digitHit, .girderHit
    );

    pixelMixer mixer (
        .frame_clk, .reset,
        .barrelHit, .digitHit, .girderHit,
        .rgb
    );

endmodule

/* testbench/donkeyScreen_chk.sv */
// assertion checker for the pixel engine: APB error timing, known color, timer direction
`timescale 1ns/1ps

module donkeyScreen_chk (
    input logic                  frame_clk,
    input logic                  reset,
    input logic                  PSEL,
    input logic                  PENABLE,
    input logic                  PSLVERR,
    input spritePkg::colorT      rgb,
    input spritePkg::frameCountT timeLeft,
    input logic                  timerRestart
);

    // error response only in the access phase
    slverrInAccess: assert property (@(posedge frame_clk) disable iff (reset)
        PSLVERR |-> (PSEL && PENABLE))
        else $error("PSLVERR high outside an APB access cycle");

    rgbKnown: assert property (@(posedge frame_clk) disable iff (reset)
        !$isunknown(rgb))
        else $error("rgb carries unknown bits after reset");

    // only a reload may move the timer upward
    timerNoRise: assert property (@(posedge frame_clk) disable iff (reset)
        (timeLeft > $past(timeLeft)) |-> $past(timerRestart))
        else $error("timeLeft rose without a restart");

endmodule

/* testbench/donkeyScreen_tb.sv */
// testbench for the pixel engine: APB setup, pixel scans and timer countdown against a model
`timescale 1ns/1ps

module donkeyScreen_tb;

    import spritePkg::*;

    localparam int TimerStart      = 6059;
    localparam int RandomCycles    = 2000;
    localparam int CountdownCycles = 6200;

    // reset, row scans, barrel windows, apb accesses, frame tests, margin
    localparam int TimeoutCycles = 10 + 10 * 451 + 2 * 441 + 20 * 3
                                   + RandomCycles + CountdownCycles + 500;

    localparam int ScanColumns [10] = '{3, 12, 20, 30, 31, 79, 81, 160, 559, 600};
    localparam int WriteData [5]    = '{12, 12, 300, 'hF9B3, 6};
    localparam int RegValue [5]     = '{12, 12, 300, 435, 6};

    // left, right, top, bottom
    localparam int GirderBox [7][4] = '{
        '{30, 610, 430, 440}, '{30, 560, 370, 380}, '{80, 610, 310, 320},
        '{30, 560, 250, 260}, '{80, 610, 190, 200}, '{30, 560, 130, 140},
        '{125, 200, 90, 100}
    };

    logic        frame_clk;
    logic        reset;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [7:0]  PADDR;
    logic [15:0] PWDATA;
    logic [15:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    logic        frameStart;
    coordT       drawX;
    coordT       drawY;
    colorT       rgb;
    frameCountT  timeLeft;

    logic        pixelValid;
    int          cycleCount = 0;
    integer      seed = 32'h153b;
    int          modelReg [5];
    int          modelTime;
    logic        restartPending;
    // cycle stamp, x, y, expected color
    logic [63:0] expQ [$];

    donkeyScreen #(
        .TimerStart      (TimerStart),
        .FramesPerSecond (60)
    ) DUT (
        .frame_clk  (frame_clk),
        .reset      (reset),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .PSLVERR    (PSLVERR),
        .frameStart (frameStart),
        .drawX      (drawX),
        .drawY      (drawY),
        .rgb        (rgb),
        .timeLeft   (timeLeft)
    );

    bind donkeyScreen donkeyScreen_chk chk (
        .frame_clk    (frame_clk),
        .reset        (reset),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PSLVERR      (PSLVERR),
        .rgb          (rgb),
        .timeLeft     (timeLeft),
        .timerRestart (timerRestart)
    );

    initial begin
        frame_clk = 1'b0;
        forever #10 frame_clk = ~frame_clk;
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic bit insideCircle(int x, int y, int cx, int cy);
        int dx;
        int dy;
        dx = x - cx;
        dy = y - cy;
        return (dx * dx + dy * dy) <= (modelReg[4] * modelReg[4]);
    endfunction

    function automatic bit glyphLit(int digit, int cx, int cy);
        string segs;
        bit    midCols;
        bit    leftCols;
        bit    rightCols;
        bit    lit;
        case (digit)
            0:       segs = "abcdef";
            1:       segs = "bc";
            2:       segs = "abdeg";
            3:       segs = "abcdg";
            4:       segs = "bcfg";
            5:       segs = "acdfg";
            6:       segs = "acdefg";
            7:       segs = "abc";
            8:       segs = "abcdefg";
            9:       segs = "abcdfg";
            default: segs = "";
        endcase
        midCols   = (cx >= 1) && (cx <= 6);
        leftCols  = cx <= 1;
        rightCols = cx >= 6;
        lit       = 1'b0;
        for (int i = 0; i < segs.len(); i++) begin
            case (segs[i])
                "a":     lit = lit | (midCols && cy <= 1);
                "b":     lit = lit | (rightCols && cy >= 1 && cy <= 7);
                "c":     lit = lit | (rightCols && cy >= 8 && cy <= 14);
                "d":     lit = lit | (midCols && cy >= 14);
                "e":     lit = lit | (leftCols && cy >= 8 && cy <= 14);
                "f":     lit = lit | (leftCols && cy >= 1 && cy <= 7);
                "g":     lit = lit | (midCols && cy >= 7 && cy <= 8);
                default: ;
            endcase
        end
        return lit;
    endfunction

    function automatic logic [11:0] expectedColor(int x, int y);
        int seconds;
        int digit;
        bit girder;
        seconds = modelTime / 60;
        case (x / 8)
            0:       digit = seconds / 100;
            1:       digit = (seconds / 10) % 10;
            default: digit = seconds % 10;
        endcase
        girder = 1'b0;
        for (int i = 0; i < 7; i++) begin
            if (x > GirderBox[i][0] && x < GirderBox[i][1]
                    && y >= GirderBox[i][2] && y <= GirderBox[i][3]) begin
                girder = 1'b1;
            end
        end
        if (insideCircle(x, y, modelReg[0], modelReg[1])
                || insideCircle(x, y, modelReg[2], modelReg[3])) begin
            return 12'hD60;
        end else if (x < 24 && y < 16 && glyphLit(digit, x % 8, y)) begin
            return 12'hFFF;
        end else if (girder) begin
            return 12'hB04;
        end else begin
            return 12'h000;
        end
    endfunction

    // expectation for each sampled pixel, then register and timer update
    always @(posedge frame_clk) begin
        if (reset) begin
            modelReg       = '{700, 700, 700, 700, 8};
            modelTime      = TimerStart;
            restartPending = 1'b0;
        end else begin
            if (pixelValid) begin
                expQ.push_back({32'(cycleCount), drawX, drawY, expectedColor(drawX, drawY)});
            end
            if (restartPending) begin
                modelTime = TimerStart;
            end else if (frameStart && modelTime > 0) begin
                modelTime = modelTime - 1;
            end
            restartPending = PSEL && PENABLE && PWRITE && (PADDR == 8'h14) && PWDATA[0];
            if (PSEL && PENABLE && PWRITE && (PADDR <= 8'h10) && (PADDR[1:0] == 2'b00)) begin
                modelReg[PADDR[4:2]] = int'(PWDATA[9:0]);
            end
        end
    end

    // rgb shows up two edges after the pixel was sampled
    always @(posedge frame_clk) begin
        logic [63:0] entry;
        if (expQ.size() > 0 && int'(expQ[0][63:32]) + 2 == cycleCount) begin
            entry = expQ.pop_front();
            checkValue($sformatf("rgb at x=%0d y=%0d", entry[31:22], entry[21:12]),
                       32'(rgb), 32'(entry[11:0]));
        end
    end

    always @(posedge frame_clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("RESULT: FAIL");
            $fatal(1, "run timed out");
        end
    end

    // ------------------------------
    // stimulus tasks
    // ------------------------------

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge frame_clk);
            pixelValid <= 1'b0;
            frameStart <= 1'b0;
        end
    endtask

    task automatic showPixel(input int x, input int y, input bit tick);
        @(posedge frame_clk);
        drawX      <= coordT'(x);
        drawY      <= coordT'(y);
        pixelValid <= 1'b1;
        frameStart <= tick;
    endtask

    task automatic apbAccess(input bit write, input logic [7:0] addr, input logic [15:0] data,
                             output logic [15:0] rdata, output logic err);
        @(posedge frame_clk);
        PSEL       <= 1'b1;
        PENABLE    <= 1'b0;
        PWRITE     <= write;
        PADDR      <= addr;
        PWDATA     <= data;
        pixelValid <= 1'b0;
        frameStart <= 1'b0;
        @(posedge frame_clk);
        PENABLE <= 1'b1;
        @(posedge frame_clk);
        rdata = PRDATA;
        err   = PSLVERR;
        checkValue("PREADY", 32'(PREADY), 32'd1);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
    endtask

    task automatic readBackRegs();
        logic [15:0] rdata;
        logic        err;
        for (int i = 0; i < 5; i++) begin
            apbAccess(1'b0, 8'(i * 4), 16'd0, rdata, err);
            checkValue($sformatf("read of 0x%0h", i * 4), 32'(rdata), 32'(RegValue[i]));
            checkValue("PSLVERR on mapped read", 32'(err), 32'd0);
        end
    endtask

    initial begin
        logic [15:0] rdata;
        logic        err;
        int          startLeft;
        int          pulses;
        bit          pulse;
        reset      = 1'b1;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = 8'd0;
        PWDATA     = 16'd0;
        frameStart = 1'b0;
        drawX      = '0;
        drawY      = '0;
        pixelValid = 1'b0;
        repeat (10) @(posedge frame_clk);
        reset <= 1'b0;

        // barrels off screen, timer shows 100
        checkValue("timeLeft after reset", 32'(timeLeft), 32'(TimerStart));
        for (int c = 0; c < 10; c++) begin
            for (int y = 0; y <= 450; y++) begin
                showPixel(ScanColumns[c], y, 1'b0);
            end
        end

        // barrel 0 over the digits, barrel 1 over the bottom girder
        for (int i = 0; i < 5; i++) begin
            apbAccess(1'b1, 8'(i * 4), 16'(WriteData[i]), rdata, err);
            checkValue("PSLVERR on mapped write", 32'(err), 32'd0);
        end
        for (int dy = -10; dy <= 10; dy++) begin
            for (int dx = -10; dx <= 10; dx++) begin
                showPixel(12 + dx, 12 + dy, 1'b0);
                showPixel(300 + dx, 435 + dy, 1'b0);
            end
        end

        // read back, then an unmapped address
        readBackRegs();
        apbAccess(1'b1, 8'h18, 16'h03FF, rdata, err);
        checkValue("PSLVERR on write to 0x18", 32'(err), 32'd1);
        apbAccess(1'b0, 8'h18, 16'd0, rdata, err);
        checkValue("PSLVERR on read of 0x18", 32'(err), 32'd1);
        checkValue("read data of 0x18", 32'(rdata), 32'd0);
        readBackRegs();

        // random frame ticks while the corner is redrawn
        idleCycles(2);
        startLeft = int'(timeLeft);
        pulses    = 0;
        for (int k = 0; k < RandomCycles; k++) begin
            pulse  = $random(seed) & 1;
            pulses = pulses + int'(pulse);
            showPixel(k % 24, (k / 24) % 16, pulse);
        end
        idleCycles(2);
        checkValue("timeLeft after random ticks", 32'(timeLeft), 32'(startLeft - pulses));

        // restart, then count all the way down
        apbAccess(1'b1, 8'h14, 16'h0001, rdata, err);
        idleCycles(2);
        checkValue("timeLeft after restart", 32'(timeLeft), 32'(TimerStart));
        for (int k = 0; k < CountdownCycles; k++) begin
            showPixel(k % 24, (k / 24) % 16, 1'b1);
        end
        idleCycles(4);
        checkValue("timeLeft at end of countdown", 32'(timeLeft), 32'd0);
        checkValue("pixels still pending", 32'(expQ.size()), 32'd0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* vlog.f */
source/spritePkg.sv
source/apbRegs.sv
source/countdownTimer.sv
source/digitGlyph.sv
source/sceneHitTest.sv
source/pixelMixer.sv
source/donkeyScreen.sv
testbench/donkeyScreen_chk.sv
testbench/donkeyScreen_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module donkeyScreen_tb \
    -f vlog.f -o donkeyScreenSim \
    && ./obj_dir/donkeyScreenSim > sim.log 2>&1 \
    || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && echo "simulation failed" && exit 1
grep -q "RESULT: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
exit 0
